// File: files.f
+incdir+design
design/msg_pkg.sv
design/msg_deserializer.sv
design/resp_serializer.sv
design/cmd6_capture.sv
design/msg_ctrl.sv
design/ice_msg_top.sv
verification/tb_ice_msg.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_ice_msg -o tb_ice_msg_sim \
    || { echo "Verilator build failed"; exit 1; }

out=$(./obj_dir/tb_ice_msg_sim) || { echo "$out"; echo "Simulation did not complete"; exit 1; }
echo "$out"

echo "$out" | grep -q "TESTBENCH PASSED" && exit 0 || exit 1

// File: verification/tb_ice_msg.sv
`timescale 1ns/10ps
`include "msg_params.svh"

module tb_ice_msg;
    import msg_pkg::*;

    logic                       sd_datInWrite_clk;
    logic                       sd_datInWrite_rst_;
    logic                       spi_data_in;
    logic                       dat_in_trigger;
    logic [`DAT_WORD_LEN-1:0]   dat_in_data;
    logic                       spi_data_out;
    logic                       spi_data_out_en;
    logic [`LED_LEN-1:0]        ice_led;
    sd_cmd_t                    sd_cmd;
    logic                       sd_cmd_trigger;

    // Reference model state
    logic [`LED_LEN-1:0]        m_led;
    sd_cmd_t                    m_cmd;
    logic                       m_trig;
    logic [`CMD6_MODE_LEN-1:0]  m_mode;
    logic                       m_captured;
    int                         m_word_idx;

    logic [15:0]                lfsr;
    int                         err_cnt;
    int                         test_cnt;
    int                         fail_cnt;

    ice_msg_top u_ice_msg_top (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .spi_data_in        (spi_data_in),
        .dat_in_trigger     (dat_in_trigger),
        .dat_in_data        (dat_in_data),
        .spi_data_out       (spi_data_out),
        .spi_data_out_en    (spi_data_out_en),
        .ice_led            (ice_led),
        .sd_cmd             (sd_cmd),
        .sd_cmd_trigger     (sd_cmd_trigger)
    );

    initial begin
        sd_datInWrite_clk = 1'b0;
        forever #10 sd_datInWrite_clk = ~sd_datInWrite_clk;
    end

    // ==================================================================
    // Random source and check helpers
    // ==================================================================
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
    endtask

    task automatic check_val(input string name, input logic [63:0] exp_v,
                             input logic [63:0] got_v);
        if (got_v !== exp_v) begin
            $display("MISMATCH %s expected %h got %h", name, exp_v, got_v);
            err_cnt++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: failed with %0d errors", name, err_cnt - errs_before);
            fail_cnt++;
        end
    endtask

    task automatic check_outputs();
        check_val("ice_led", 64'(m_led), 64'(ice_led));
        check_val("sd_cmd", 64'(m_cmd), 64'(sd_cmd));
        check_val("sd_cmd_trigger", 64'(m_trig), 64'(sd_cmd_trigger));
    endtask

    // ==================================================================
    // Host side message and response
    // ==================================================================
    // Bits change 2 ns after each edge and the line idles after E63
    task automatic send_msg(input logic [63:0] m);
        for (int i = `MSG_LEN - 1; i >= 0; i--) begin
            spi_data_in = m[i];
            @(posedge sd_datInWrite_clk);
            #2;
        end
        spi_data_in = 1'b0;     // Line back to idle
    endtask

    task automatic model_msg(input logic [63:0] m);
        case (m[63:56])
            `MSG_TYPE_LEDSET: m_led = m[3:0];
            `MSG_TYPE_SDSENDCMD: begin
                m_cmd.cmd_data        = m[47:0];
                m_cmd.resp_type       = m[49:48];
                m_cmd.dat_in_expected = m[50];
                m_trig = ~m_trig;
                if (m[50]) begin
                    m_word_idx = 0;     // Re-arm keeps the mode
                    m_captured = 1'b0;
                end
            end
            default: ;
        endcase
    endtask

    task automatic collect_resp(output logic [63:0] r, output int lead, output int len);
        r    = '0;
        lead = 0;
        len  = 0;
        while (!spi_data_out_en && lead < 8) begin
            @(posedge sd_datInWrite_clk);
            #2;
            lead++;
        end
        if (!spi_data_out_en) begin
            $display("ERROR: response enable did not rise within %0d cycles", lead);
            err_cnt++;
        end else begin
            while (spi_data_out_en && len < 70) begin
                r = {r[62:0], spi_data_out};
                len++;
                @(posedge sd_datInWrite_clk);
                #2;
            end
            if (spi_data_out_en) begin
                $display("ERROR: response enable stuck high after %0d cycles", len);
                err_cnt++;
            end
        end
    endtask

    // Enable rises after E65, which is 2 edges after E63
    task automatic expect_resp(input logic [63:0] m, input logic [63:0] exp_r);
        logic [63:0] r;
        int          lead;
        int          len;
        send_msg(m);
        collect_resp(r, lead, len);
        check_val("resp", exp_r, r);
        check_val("resp_lead_cycles", 64'(2), 64'(lead));
        check_val("spi_data_out_en_cycles", 64'(64), 64'(len));
    endtask

    task automatic expect_no_resp(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            if (spi_data_out_en) begin
                $display("ERROR: unexpected response enable at cycle %0d", i);
                err_cnt++;
                break;
            end
            @(posedge sd_datInWrite_clk);
            #2;
        end
    endtask

    task automatic status_check();
        expect_resp({`MSG_TYPE_SDSTATUS, 56'h0},
                    {m_mode, m_captured, 11'h0, m_cmd.cmd_data});
    endtask

    // Random stream of data-in words with 0 to 3 idle cycles between them
    task automatic send_words(input int n);
        logic [63:0] v;
        for (int i = 0; i < n; i++) begin
            take_bits(`DAT_WORD_LEN, v);
            dat_in_trigger = 1'b1;
            dat_in_data    = v[15:0];
            if (!m_captured) begin
                if (m_word_idx == `CMD6_WORD_IDX) begin
                    m_mode     = v[`CMD6_MODE_LSB +: `CMD6_MODE_LEN];
                    m_captured = 1'b1;
                end else begin
                    m_word_idx++;
                end
            end
            @(posedge sd_datInWrite_clk);
            #2;
            dat_in_trigger = 1'b0;
            take_bits(2, v);
            repeat (v[1:0]) begin
                @(posedge sd_datInWrite_clk);
                #2;
            end
        end
    endtask

    task automatic arm_cmd();
        logic [63:0] v;
        logic [63:0] m;
        take_bits(50, v);
        m = {`MSG_TYPE_SDSENDCMD, 5'h0, 1'b1, v[49:0]};
        send_msg(m);
        model_msg(m);
        @(posedge sd_datInWrite_clk);
        #2;
        check_outputs();
        repeat (2) @(posedge sd_datInWrite_clk);     // Arm lands before the words
        #2;
    endtask

    // ==================================================================
    // Test sequence
    // ==================================================================
    initial begin
        logic [63:0] v;
        logic [63:0] m;
        logic [7:0]  t;
        int          errs;
        sd_datInWrite_rst_ = 1'b0;
        spi_data_in        = 1'b0;
        dat_in_trigger     = 1'b0;
        dat_in_data        = '0;
        lfsr               = 16'd48837;
        err_cnt            = 0;
        test_cnt           = 0;
        fail_cnt           = 0;
        m_led              = '0;
        m_cmd              = '0;
        m_trig             = 1'b0;
        m_mode             = '0;
        m_captured         = 1'b0;
        m_word_idx         = 0;
        repeat (8) @(posedge sd_datInWrite_clk);
        #2;
        sd_datInWrite_rst_ = 1'b1;

        errs = err_cnt;
        check_val("spi_data_out_en", 64'h0, 64'(spi_data_out_en));
        check_outputs();
        end_test("reset", errs);

        errs = err_cnt;
        for (int i = 0; i < 20; i++) begin
            take_bits(`MSG_ARG_LEN, v);
            expect_resp({`MSG_TYPE_ECHO, v[55:0]}, {v[55:0], 8'h0});
        end
        end_test("echo", errs);

        errs = err_cnt;
        for (int i = 0; i < 16; i++) begin
            take_bits(1 + `MSG_ARG_LEN, v);
            m = {(v[56] ? `MSG_TYPE_SDSENDCMD : `MSG_TYPE_LEDSET), v[55:0]};
            send_msg(m);
            model_msg(m);
            @(posedge sd_datInWrite_clk);   // Decode edge E64
            #2;
            check_outputs();
            expect_no_resp(4);
        end
        end_test("led_sdcmd", errs);

        errs = err_cnt;
        arm_cmd();
        send_words(12);
        status_check();
        arm_cmd();
        status_check();     // Captured now clear while the old mode stays
        send_words(12);
        status_check();
        end_test("cmd6_capture", errs);

        errs = err_cnt;
        for (int i = 0; i < 8; i++) begin
            t = `MSG_TYPE_NOP;
            while (t == `MSG_TYPE_NOP || t == `MSG_TYPE_LEDSET ||
                   t == `MSG_TYPE_SDSENDCMD || t == `MSG_TYPE_ECHO ||
                   t == `MSG_TYPE_SDSTATUS) begin
                take_bits(7, v);
                t = {1'b1, v[6:0]};
            end
            take_bits(`MSG_ARG_LEN, v);
            send_msg({t, v[55:0]});
            expect_no_resp(140);
            check_outputs();
        end
        take_bits(`MSG_ARG_LEN, v);
        expect_resp({`MSG_TYPE_ECHO, v[55:0]}, {v[55:0], 8'h0});
        end_test("unknown_types", errs);

        $display("Tests run %0d, tests failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: design/ice_msg_top.sv
`timescale 1ns/10ps
`include "msg_params.svh"

module ice_msg_top (
    input  logic                        sd_datInWrite_clk,
    input  logic                        sd_datInWrite_rst_,
    input  logic                        spi_data_in,
    input  logic                        dat_in_trigger,
    input  logic [`DAT_WORD_LEN-1:0]    dat_in_data,
    output logic                        spi_data_out,
    output logic                        spi_data_out_en,
    output logic [`LED_LEN-1:0]         ice_led,
    output msg_pkg::sd_cmd_t            sd_cmd,
    output logic                        sd_cmd_trigger
);
    import msg_pkg::*;

    // ==================================================================
    // Internal nets
    // ==================================================================
    logic                   msg_valid;
    msg_t                   msg;
    logic                   rx_enable;
    logic                   resp_load;
    logic [`RESP_LEN-1:0]   resp;
    logic                   busy;
    logic                   cmd6_arm;
    cmd6_status_t           cmd6_status;

    msg_deserializer u_msg_deserializer (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .rx_enable          (rx_enable),
        .spi_data_in        (spi_data_in),
        .msg_valid          (msg_valid),
        .msg                (msg)
    );

    msg_ctrl u_msg_ctrl (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .msg_valid          (msg_valid),
        .msg                (msg),
        .busy               (busy),
        .cmd6_status        (cmd6_status),
        .rx_enable          (rx_enable),
        .resp_load          (resp_load),
        .cmd6_arm           (cmd6_arm),
        .sd_cmd_trigger     (sd_cmd_trigger),   // Toggle
        .resp               (resp),
        .ice_led            (ice_led),
        .sd_cmd             (sd_cmd)
    );

    resp_serializer u_resp_serializer (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .resp_load          (resp_load),
        .resp               (resp),
        .spi_data_out       (spi_data_out),
        .spi_data_out_en    (spi_data_out_en),
        .busy               (busy)
    );

    // Data-in words are always accepted
    cmd6_capture u_cmd6_capture (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .cmd6_arm           (cmd6_arm),
        .dat_in_trigger     (dat_in_trigger),
        .dat_in_data        (dat_in_data),
        .cmd6_status        (cmd6_status)
    );

endmodule

// File: design/msg_ctrl.sv
`timescale 1ns/10ps
`include "msg_params.svh"

module msg_ctrl (
    input  logic                    sd_datInWrite_clk,
    input  logic                    sd_datInWrite_rst_,
    input  logic                    msg_valid,
    input  msg_pkg::msg_t           msg,
    input  logic                    busy,
    input  msg_pkg::cmd6_status_t   cmd6_status,
    output logic                    rx_enable,
    output logic                    resp_load,
    output logic                    cmd6_arm,
    output logic                    sd_cmd_trigger,
    output logic [`RESP_LEN-1:0]    resp,
    output logic [`LED_LEN-1:0]     ice_led,
    output msg_pkg::sd_cmd_t        sd_cmd
);
    import msg_pkg::*;

    typedef enum logic [1:0] {
        state_receive,      // Waiting for a message
        state_resp_wait,    // Response loaded, serializer not yet busy
        state_hold          // Response on the line
    } state_t;

    state_t  state;
    sd_cmd_t cmd_arg;       // SDSendCmd argument viewed as a command
    logic    want_resp;

    assign cmd_arg   = sd_cmd_t'(msg.arg[`SD_CMD_ARG_LEN-1:0]);
    assign want_resp = msg.msg_type[`MSG_TYPE_RESP_BIT];

    // Receiver stays off from decode until the response has gone out
    always_comb begin
        case (state)
            state_receive: rx_enable = !msg_valid;
            state_hold:    rx_enable = !busy;
            default:       rx_enable = 1'b0;
        endcase
    end

    // ==================================================================
    // Control FSM and command decode
    // ==================================================================
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            state          <= state_receive;
            resp_load      <= 1'b0;
            cmd6_arm       <= 1'b0;
            sd_cmd_trigger <= 1'b0;
            ice_led        <= '0;
            sd_cmd         <= '0;
        end else begin
            resp_load <= 1'b0;
            cmd6_arm  <= 1'b0;

            case (state)
                state_receive: begin
                    if (msg_valid) begin
                        if (want_resp) begin
                            case (msg.msg_type)
                                `MSG_TYPE_ECHO,
                                `MSG_TYPE_SDSTATUS: begin
                                    resp_load <= 1'b1;
                                    state     <= state_resp_wait;
                                end
                                default: ;  // Unknown, no answer
                            endcase
                        end else begin
                            case (msg.msg_type)
                                `MSG_TYPE_LEDSET: begin
                                    ice_led <= msg.arg[`LED_LEN-1:0];
                                end
                                `MSG_TYPE_SDSENDCMD: begin
                                    sd_cmd         <= cmd_arg;
                                    sd_cmd_trigger <= !sd_cmd_trigger;  // Toggle
                                    cmd6_arm       <= cmd_arg.dat_in_expected;
                                end
                                default: ;  // Nop and unknown types
                            endcase
                        end
                    end
                end

                state_resp_wait: begin
                    if (busy) begin
                        state <= state_hold;
                    end
                end

                state_hold: begin
                    if (!busy) begin
                        state <= state_receive;     // Last bit has left
                    end
                end

                default: begin
                    state <= state_receive;
                end
            endcase
        end
    end

    // ==================================================================
    // Response build
    // ==================================================================
    always_ff @(posedge sd_datInWrite_clk) begin
        if (state == state_receive && msg_valid) begin
            case (msg.msg_type)
                `MSG_TYPE_ECHO: begin
                    resp <= {msg.arg, {`RESP_ECHO_PAD_LEN{1'b0}}};
                end
                `MSG_TYPE_SDSTATUS: begin
                    // Mode 63..60, captured 59, last command data 47..0
                    resp <= {cmd6_status.access_mode,
                             cmd6_status.captured,
                             {`RESP_STATUS_PAD_LEN{1'b0}},
                             sd_cmd.cmd_data};
                end
                default: ;
            endcase
        end
    end

endmodule

// File: design/cmd6_capture.sv
`timescale 1ns/10ps
`include "msg_params.svh"

module cmd6_capture (
    input  logic                        sd_datInWrite_clk,
    input  logic                        sd_datInWrite_rst_,
    input  logic                        cmd6_arm,
    input  logic                        dat_in_trigger,
    input  logic [`DAT_WORD_LEN-1:0]    dat_in_data,
    output msg_pkg::cmd6_status_t       cmd6_status
);
    import msg_pkg::*;

    localparam int cnt_w = $clog2(`CMD6_WORD_IDX + 1);

    logic [cnt_w-1:0] word_cnt;     // Index of the next data-in word
    cmd6_status_t     status_q;

    assign cmd6_status = status_q;

    // ==================================================================
    // Word counter and access mode capture
    // ==================================================================
    // Armed while captured is clear, counting stops once the mode is in
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            word_cnt             <= '0;
            status_q.captured    <= 1'b0;
            status_q.access_mode <= '0;
        end else if (cmd6_arm) begin
            // Re-arm beats a word in the same cycle
            word_cnt          <= '0;
            status_q.captured <= 1'b0;
        end else if (dat_in_trigger && !status_q.captured) begin
            if (word_cnt == cnt_w'(`CMD6_WORD_IDX)) begin
                status_q.access_mode <=
                    dat_in_data[`CMD6_MODE_LSB +: `CMD6_MODE_LEN];
                status_q.captured    <= 1'b1;
            end else begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

endmodule

// File: design/resp_serializer.sv
`timescale 1ns/10ps
`include "msg_params.svh"

module resp_serializer (
    input  logic                    sd_datInWrite_clk,
    input  logic                    sd_datInWrite_rst_,
    input  logic                    resp_load,
    input  logic [`RESP_LEN-1:0]    resp,
    output logic                    spi_data_out,
    output logic                    spi_data_out_en,
    output logic                    busy
);
    localparam int cnt_w = $clog2(`RESP_LEN);

    logic [`RESP_LEN-1:0] shift_reg;
    logic [cnt_w-1:0]     bit_cnt;

    // MSB of the shifter is the bit on the line
    assign spi_data_out = spi_data_out_en & shift_reg[`RESP_LEN-1];
    assign busy         = spi_data_out_en;

    // ==================================================================
    // Output enable window, 64 cycles from load
    // ==================================================================
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            spi_data_out_en <= 1'b0;
            bit_cnt         <= '0;
        end else if (resp_load) begin
            spi_data_out_en <= 1'b1;
            bit_cnt         <= '0;
        end else if (spi_data_out_en) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == cnt_w'(`RESP_LEN - 1)) begin
                spi_data_out_en <= 1'b0;    // Bit 0 has had its cycle
            end
        end
    end

    always_ff @(posedge sd_datInWrite_clk) begin
        if (resp_load) begin
            shift_reg <= resp;
        end else if (spi_data_out_en) begin
            shift_reg <= {shift_reg[`RESP_LEN-2:0], 1'b0};
        end
    end

endmodule

// File: design/msg_deserializer.sv
`timescale 1ns/10ps
`include "msg_params.svh"

module msg_deserializer (
    input  logic            sd_datInWrite_clk,
    input  logic            sd_datInWrite_rst_,
    input  logic            rx_enable,
    input  logic            spi_data_in,
    output logic            msg_valid,
    output msg_pkg::msg_t   msg
);
    import msg_pkg::*;

    localparam int cnt_w = $clog2(`MSG_LEN);

    logic               receiving;
    logic [cnt_w-1:0]   bit_cnt;    // Bits already taken in this message
    logic [`MSG_LEN-1:0] shift_reg;

    assign msg = msg_t'(shift_reg);

    // ==================================================================
    // Start detection and shift-in
    // ==================================================================
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            receiving <= 1'b0;
            bit_cnt   <= '0;
            msg_valid <= 1'b0;
        end else begin
            msg_valid <= 1'b0;
            if (!receiving) begin
                // Idle line is low, first high bit is type bit 7
                if (rx_enable && spi_data_in) begin
                    receiving <= 1'b1;
                    bit_cnt   <= cnt_w'(1);
                end
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == cnt_w'(`MSG_LEN - 1)) begin
                    receiving <= 1'b0;  // Last bit in
                    msg_valid <= 1'b1;
                end
            end
        end
    end

    // Payload shifter
    always_ff @(posedge sd_datInWrite_clk) begin
        if (receiving || (rx_enable && spi_data_in)) begin
            shift_reg <= {shift_reg[`MSG_LEN-2:0], spi_data_in};
        end
    end

endmodule

// File: design/msg_pkg.sv
package msg_pkg;

    `include "msg_params.svh"

    // ==================================================================
    // Host message, MSB first on the wire
    // ==================================================================
    typedef struct packed {
        logic [`MSG_TYPE_LEN-1:0] msg_type;   // Bits 63..56
        logic [`MSG_ARG_LEN-1:0]  arg;        // Bits 55..0
    } msg_t;

    // SD command as handed to the SD controller
    // Field order follows argument bits 50..0 of SDSendCmd
    typedef struct packed {
        logic                         dat_in_expected;  // Arg bit 50
        logic [`SD_RESP_TYPE_LEN-1:0] resp_type;        // Arg bits 49..48
        logic [`SD_CMD_LEN-1:0]       cmd_data;         // Arg bits 47..0
    } sd_cmd_t;

    // CMD6 capture result
    typedef struct packed {
        logic                      captured;
        logic [`CMD6_MODE_LEN-1:0] access_mode;
    } cmd6_status_t;

endpackage

// File: design/msg_params.svh
`ifndef MSG_PARAMS_SVH
`define MSG_PARAMS_SVH

// ======================================================================
// Message framing
// ======================================================================
`define MSG_LEN                 64
`define RESP_LEN                64
`define MSG_TYPE_LEN            8
`define MSG_ARG_LEN             56
`define MSG_TYPE_RESP_BIT       6   // Set on types that answer

// Message type codes, bit 7 always set as start marker
`define MSG_TYPE_NOP            8'h80
`define MSG_TYPE_LEDSET         8'h81
`define MSG_TYPE_SDSENDCMD      8'h82
`define MSG_TYPE_ECHO           8'hC0
`define MSG_TYPE_SDSTATUS       8'hC1

// ======================================================================
// SD command and data-in fields
// ======================================================================
`define SD_CMD_LEN              48
`define SD_RESP_TYPE_LEN        2
`define SD_CMD_ARG_LEN          (`SD_CMD_LEN + `SD_RESP_TYPE_LEN + 1)  // Arg bits 50..0
`define DAT_WORD_LEN            16
`define CMD6_WORD_IDX           8
`define CMD6_MODE_LSB           8
`define CMD6_MODE_LEN           4

`define LED_LEN                 4
`define RESP_ECHO_PAD_LEN       8   // Zero bits below the echoed argument
`define RESP_STATUS_PAD_LEN     11  // Zero bits 58..48 of SDStatus

`endif
